//--- compile.f
logic/bus_pkg.sv
logic/map_pkg.sv
logic/dev_bus_if.sv
logic/host_port.sv
logic/sys_bridge.sv
logic/timer_counter.sv
logic/data_ram.sv
logic/mips_sys_top.sv
dv/mips_sys_tb.sv

//--- dv/mips_sys_tb.sv
module mips_sys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 64;
    localparam int ACK_LIMIT = 10;
    localparam logic [31:0] CTRL_MASK = (32'd1 << map_pkg::CTRL_W) - 32'd1;

    localparam int KIND_WRITE     = 0;
    localparam int KIND_READ      = 1;
    localparam int KIND_READ_MAX  = 2;
    localparam int KIND_WAIT_IRQ  = 3;
    localparam int KIND_PULSES    = 4;
    localparam int KIND_INT_RESP  = 5;
    localparam int KIND_INT_WRITE = 6;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        ack;
    logic [31:0] rdata;
    logic        ext_int;
    logic        int_ack;
    logic        irq;
    logic [31:0] int_addr;
    logic [3:0]  int_byteen;

    // Test table
    string       t_name [MAX_TESTS];
    int          t_kind [MAX_TESTS];
    logic [31:0] t_addr [MAX_TESTS];
    logic [31:0] t_data [MAX_TESTS];
    logic [3:0]  t_be   [MAX_TESTS];
    logic [31:0] t_exp  [MAX_TESTS];
    int          n_tests;

    // Reference model of RAM and timer registers
    logic [31:0] ram_model [int];
    logic [31:0] tc_ctrl   [2];
    logic [31:0] tc_preset [2];
    logic [31:0] tc_count  [2];

    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int          cycle_limit;
    bit          test_ok;
    logic [31:0] seen_addr;
    logic [3:0]  seen_be;

    mips_sys_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .addr       (addr),
        .wdata      (wdata),
        .be         (be),
        .ack        (ack),
        .rdata      (rdata),
        .ext_int    (ext_int),
        .int_ack    (int_ack),
        .irq        (irq),
        .int_addr   (int_addr),
        .int_byteen (int_byteen)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Last interrupt response seen on the port
    always @(negedge clk) begin
        if (int_byteen !== 4'b0000) begin
            seen_addr = int_addr;
            seen_be   = int_byteen;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lane_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  lanes
    );
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic int timer_index(input logic [31:0] a);
        if (a >= map_pkg::TC0_BASE && a <= map_pkg::TC0_LAST) begin
            return 0;
        end
        if (a >= map_pkg::TC1_BASE && a <= map_pkg::TC1_LAST) begin
            return 1;
        end
        return -1;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        int t;
        t = timer_index(a);
        if (a <= map_pkg::RAM_LAST) begin
            return ram_model.exists(int'(a[13:2])) ? ram_model[int'(a[13:2])] : 32'h0;
        end else if (t >= 0) begin
            case (a[3:2])
                2'd0:    return tc_ctrl[t];
                2'd1:    return tc_preset[t];
                2'd2:    return tc_count[t];
                default: return 32'h0;
            endcase
        end
        return 32'h0;
    endfunction

    task automatic add_test(input string name, input int kind, input logic [31:0] a,
                            input logic [31:0] d, input logic [3:0] b,
                            input logic [31:0] exp);
        t_name[n_tests] = name;
        t_kind[n_tests] = kind;
        t_addr[n_tests] = a;
        t_data[n_tests] = d;
        t_be[n_tests]   = b;
        t_exp[n_tests]  = exp;
        n_tests++;
    endtask

    task automatic host_write(input string name, input logic [31:0] a,
                              input logic [31:0] d, input logic [3:0] b);
        int t;
        add_test(name, KIND_WRITE, a, d, b, 32'h0);
        t = timer_index(a);
        if (a <= map_pkg::RAM_LAST) begin
            ram_model[int'(a[13:2])] = lane_merge(model_read(a), d, b);
        end else if (t >= 0 && a[3:2] == 2'd0) begin
            tc_ctrl[t] = lane_merge(tc_ctrl[t], d, b) & CTRL_MASK;
        end else if (t >= 0 && a[3:2] == 2'd1) begin
            // PRESET write also loads COUNT
            tc_preset[t] = lane_merge(tc_preset[t], d, b);
            tc_count[t]  = tc_preset[t];
        end
    endtask

    task automatic expect_read(input string name, input logic [31:0] a);
        add_test(name, KIND_READ, a, 32'h0, 4'h0, model_read(a));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////
    task automatic build_table();
        logic [31:0] ram_addr [4];
        logic [3:0]  ram_be   [4];
        ram_addr = '{32'h0000_0000, 32'h0000_0104, 32'h0000_1a38, 32'h0000_2ffc};
        ram_be   = '{4'b0101, 4'b1000, 4'b0110, 4'b0011};
        n_tests  = 0;
        for (int t = 0; t < 2; t++) begin
            tc_ctrl[t]   = 32'h0;
            tc_preset[t] = 32'h0;
            tc_count[t]  = 32'h0;
        end

        for (int k = 0; k < 4; k++) begin
            host_write($sformatf("ram_full_wr_%0d", k), ram_addr[k], $urandom(), 4'hf);
            host_write($sformatf("ram_lane_wr_%0d", k), ram_addr[k], $urandom(), ram_be[k]);
            expect_read($sformatf("ram_rd_%0d", k), ram_addr[k]);
        end
        expect_read("unmapped_rd_5000", 32'h0000_5000);
        expect_read("unmapped_rd_7f30", 32'h0000_7f30);

        host_write("tc0_preset_wr", 32'h7f04, 32'h0000_1234, 4'hf);
        host_write("tc0_ctrl_wr", 32'h7f00, 32'h0000_000a, 4'hf);
        host_write("tc0_count_wr", 32'h7f08, 32'h0000_0055, 4'hf);
        expect_read("tc0_ctrl_rd", 32'h7f00);
        expect_read("tc0_preset_rd", 32'h7f04);
        expect_read("tc0_count_rd", 32'h7f08);
        host_write("tc1_preset_wr", 32'h7f14, 32'h0000_beef, 4'hf);
        host_write("tc1_ctrl_wr", 32'h7f10, 32'h0000_0006, 4'hf);
        expect_read("tc1_ctrl_rd", 32'h7f10);
        expect_read("tc1_preset_rd", 32'h7f14);
        expect_read("tc0_ctrl_kept", 32'h7f00);
        expect_read("tc0_preset_kept", 32'h7f04);

        // One-shot with EN, mode 0 and IM
        host_write("os_ctrl_off", 32'h7f00, 32'h0, 4'hf);
        host_write("os_preset", 32'h7f04, 32'd20, 4'hf);
        host_write("os_start", 32'h7f00, 32'h0000_0009, 4'hf);
        add_test("os_irq_rise", KIND_WAIT_IRQ, 32'h0, 32'd40, 4'h0, 32'h1);
        tc_count[0] = 32'h0;
        tc_ctrl[0]  = tc_ctrl[0] & ~(32'd1 << map_pkg::CTRL_EN);
        expect_read("os_count_zero", 32'h7f08);
        expect_read("os_en_clear", 32'h7f00);
        host_write("os_ctrl_clear", 32'h7f00, 32'h0, 4'hf);
        add_test("os_irq_drop", KIND_WAIT_IRQ, 32'h0, 32'd2, 4'h0, 32'h0);

        // Reload with EN, mode 1 and IM
        host_write("rl_ctrl_off", 32'h7f10, 32'h0, 4'hf);
        host_write("rl_preset", 32'h7f14, 32'd12, 4'hf);
        host_write("rl_start", 32'h7f10, 32'h0000_000b, 4'hf);
        add_test("rl_pulses", KIND_PULSES, 32'h0, 32'd100, 4'h0, 32'd2);
        for (int k = 0; k < 3; k++) begin
            add_test($sformatf("rl_count_max_%0d", k), KIND_READ_MAX, 32'h7f18,
                     32'h0, 4'h0, 32'd12);
        end
        host_write("rl_stop", 32'h7f10, 32'h0, 4'hf);

        // Data bit 1 drives ext_int and bit 0 drives int_ack
        add_test("int_resp_both", KIND_INT_RESP, 32'h0, 32'h3, 4'b0001, 32'h7f20);
        add_test("int_resp_ext", KIND_INT_RESP, 32'h0, 32'h2, 4'b0000, 32'h0);
        add_test("int_resp_ack", KIND_INT_RESP, 32'h0, 32'h1, 4'b0000, 32'h0);
        add_test("int_resp_none", KIND_INT_RESP, 32'h0, 32'h0, 4'b0000, 32'h0);
        add_test("int_host_wr", KIND_INT_WRITE, 32'h7f21, 32'h0000_00a5, 4'b0001, 32'h7f21);
        expect_read("int_tc0_kept", 32'h7f00);
        expect_read("int_tc1_kept", 32'h7f10);
        expect_read("int_ram_kept", 32'h0000_0000);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Handshake driver and checks
    //////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
        test_ok = 0;
    endtask

    task automatic bus_access(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] b, output logic [31:0] rd);
        int waited;
        rd = 32'h0;
        if (ack !== 1'b0) begin
            $display("ERROR: ack is high before req was raised");
            test_ok = 0;
        end
        @(posedge clk);
        #1;
        req   = 1'b1;
        addr  = a;
        wdata = d;
        be    = b;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b1) begin
            $display("ERROR: no ack within %0d cycles of req", ACK_LIMIT);
            test_ok = 0;
        end else begin
            rd = rdata;
            // Hold req one more cycle
            @(negedge clk);
            if (ack !== 1'b1 || rdata !== rd) begin
                $display("ERROR: ack or rdata changed while req was held high");
                test_ok = 0;
            end
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b0 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b0) begin
            $display("ERROR: ack stayed high after req fell");
            test_ok = 0;
        end
    endtask

    task automatic run_test(input int i);
        logic [31:0] rd;
        int          cycles;
        int          pulses;
        logic        prev_irq;
        test_ok = 1;
        case (t_kind[i])
            KIND_WRITE: begin
                bus_access(t_addr[i], t_data[i], t_be[i], rd);
            end
            KIND_READ: begin
                bus_access(t_addr[i], 32'h0, 4'h0, rd);
                if (rd !== t_exp[i]) begin
                    report_mismatch(t_name[i], t_exp[i], rd);
                end
            end
            KIND_READ_MAX: begin
                bus_access(t_addr[i], 32'h0, 4'h0, rd);
                if ($isunknown(rd) || rd > t_exp[i]) begin
                    $display("ERROR: %s read COUNT %h above PRESET %h", t_name[i], rd, t_exp[i]);
                    test_ok = 0;
                end
            end
            KIND_WAIT_IRQ: begin
                cycles = 0;
                @(negedge clk);
                while (irq !== t_exp[i][0] && cycles < int'(t_data[i])) begin
                    @(negedge clk);
                    cycles++;
                end
                if (irq !== t_exp[i][0]) begin
                    report_mismatch(t_name[i], t_exp[i], {31'h0, irq});
                end
            end
            KIND_PULSES: begin
                pulses = 0;
                @(negedge clk);
                prev_irq = irq;
                for (cycles = 0; cycles < int'(t_data[i]); cycles++) begin
                    @(negedge clk);
                    if (irq === 1'b1 && prev_irq !== 1'b1) begin
                        pulses++;
                    end
                    prev_irq = irq;
                end
                if (pulses < int'(t_exp[i])) begin
                    $display("ERROR: %s saw %0d irq pulses, fewer than %0d",
                             t_name[i], pulses, t_exp[i]);
                    test_ok = 0;
                end
            end
            KIND_INT_RESP: begin
                @(posedge clk);
                #1;
                ext_int = t_data[i][1];
                int_ack = t_data[i][0];
                @(negedge clk);
                if (int_addr !== t_exp[i]) begin
                    report_mismatch({t_name[i], "/addr"}, t_exp[i], int_addr);
                end
                if (int_byteen !== t_be[i]) begin
                    report_mismatch({t_name[i], "/byteen"}, {28'h0, t_be[i]},
                                    {28'h0, int_byteen});
                end
            end
            default: begin
                seen_addr = 32'h0;
                seen_be   = 4'h0;
                bus_access(t_addr[i], t_data[i], t_be[i], rd);
                if (seen_addr !== t_exp[i]) begin
                    report_mismatch({t_name[i], "/addr"}, t_exp[i], seen_addr);
                end
                if (seen_be !== 4'b0001) begin
                    report_mismatch({t_name[i], "/byteen"}, 32'h1, {28'h0, seen_be});
                end
            end
        endcase
        if (test_ok) begin
            pass_count++;
            $display("PASS  %s", t_name[i]);
        end else begin
            fail_count++;
            $display("FAIL  %s", t_name[i]);
        end
    endtask

    initial begin
        void'($urandom(84681));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        addr        = 32'h0;
        wdata       = 32'h0;
        be          = 4'h0;
        ext_int     = 1'b0;
        int_ack     = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        test_ok     = 1;
        seen_addr   = 32'h0;
        seen_be     = 4'h0;
        build_table();
        cycle_limit = 40 * n_tests + 200;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ERROR: ack is not low after reset");
            fail_count++;
        end

        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- logic/bus_pkg.sv
package bus_pkg;

    // Host bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // One access as latched by the host front end
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } bus_req_t;

    // Any enabled byte lane makes the access a store
    function automatic logic is_write(
        input logic [BE_W-1:0] be
    );
        return |be;
    endfunction

    // Replace the enabled byte lanes of old_word with those of new_word
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                word[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return word;
    endfunction

endpackage

//--- logic/data_ram.sv
module data_ram (
    input logic    clk,
    dev_bus_if.dev bus
);

    logic [bus_pkg::DATA_W-1:0]    mem [map_pkg::RAM_WORDS];
    logic [map_pkg::RAM_IDX_W-1:0] idx;
    logic                          idx_ok;

    // Word index from the byte address
    assign idx    = bus.addr[map_pkg::RAM_IDX_W+1:2];
    assign idx_ok = (32'(idx) < map_pkg::RAM_WORDS);

    // Byte-lane store
    always_ff @(posedge clk) begin
        if (bus.sel && bus_pkg::is_write(bus.be) && idx_ok) begin
            mem[idx] <= bus_pkg::merge_bytes(mem[idx], bus.wdata, bus.be);
        end
    end

    // Asynchronous read, indices past the last word read as zero
    always_comb begin
        if (idx_ok) begin
            bus.rdata = mem[idx];
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

//--- logic/dev_bus_if.sv
// One memory-mapped access channel between an initiator and a device
interface dev_bus_if (
    input logic clk
);

    logic [bus_pkg::ADDR_W-1:0] addr;
    logic [bus_pkg::DATA_W-1:0] wdata;
    logic [bus_pkg::BE_W-1:0]   be;
    logic [bus_pkg::DATA_W-1:0] rdata;
    logic                       sel;

    // Initiator side
    modport host (
        input  clk,
        output addr,
        output wdata,
        output be,
        output sel,
        input  rdata
    );

    // Target side, rdata is combinational from addr
    modport dev (
        input  clk,
        input  addr,
        input  wdata,
        input  be,
        input  sel,
        output rdata
    );

endinterface

//--- logic/host_port.sv
module host_port (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  logic [bus_pkg::ADDR_W-1:0] addr,
    input  logic [bus_pkg::DATA_W-1:0] wdata,
    input  logic [bus_pkg::BE_W-1:0]   be,
    output logic                       ack,
    output logic [bus_pkg::DATA_W-1:0] rdata,
    dev_bus_if.host                    bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t            state;
    bus_pkg::bus_req_t req_q;
    logic [bus_pkg::DATA_W-1:0] rdata_q;

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            // ack trails the DONE state by one cycle on both edges
            ack <= (state == ST_DONE);
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    // Host keeps req high, we just keep waiting
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request latch and read data capture
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
            req_q.be    <= be;
        end
        if (state == ST_ACCESS) begin
            rdata_q <= bus.rdata;
        end
    end

    // Single-cycle access toward the bridge
    assign bus.sel   = (state == ST_ACCESS);
    assign bus.addr  = req_q.addr;
    assign bus.wdata = req_q.wdata;
    assign bus.be    = req_q.be;
    assign rdata     = rdata_q;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    sel_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bus.sel |=> !bus.sel)
        else $error("bus sel held for more than one cycle");

endmodule

//--- logic/map_pkg.sv
package map_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address map, inclusive byte windows
    //////////////////////////////////////////////////////////////////////
    localparam logic [bus_pkg::ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] RAM_LAST = 32'h0000_2fff;
    localparam logic [bus_pkg::ADDR_W-1:0] TC0_BASE = 32'h0000_7f00;
    localparam logic [bus_pkg::ADDR_W-1:0] TC0_LAST = 32'h0000_7f0b;
    localparam logic [bus_pkg::ADDR_W-1:0] TC1_BASE = 32'h0000_7f10;
    localparam logic [bus_pkg::ADDR_W-1:0] TC1_LAST = 32'h0000_7f1b;
    localparam logic [bus_pkg::ADDR_W-1:0] INT_BASE = 32'h0000_7f20;
    localparam logic [bus_pkg::ADDR_W-1:0] INT_LAST = 32'h0000_7f23;

    localparam int RAM_WORDS = 3072;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    //////////////////////////////////////////////////////////////////////
    // Timer register layout
    //////////////////////////////////////////////////////////////////////
    localparam logic [3:0] TC_CTRL   = 4'h0;
    localparam logic [3:0] TC_PRESET = 4'h4;
    localparam logic [3:0] TC_COUNT  = 4'h8;

    // CTRL fields
    localparam int CTRL_EN      = 0;
    localparam int CTRL_MODE_LO = 1;
    localparam int CTRL_MODE_W  = 2;
    localparam int CTRL_IM      = 3;
    localparam int CTRL_W       = 4;

    localparam logic [CTRL_MODE_W-1:0] MODE_ONESHOT = 2'd0;
    localparam logic [CTRL_MODE_W-1:0] MODE_RELOAD  = 2'd1;

endpackage

//--- logic/mips_sys_top.sv
module mips_sys_top (
    input  logic                       clk,
    input  logic                       rst,

    // Host handshake
    input  logic                       req,
    input  logic [bus_pkg::ADDR_W-1:0] addr,
    input  logic [bus_pkg::DATA_W-1:0] wdata,
    input  logic [bus_pkg::BE_W-1:0]   be,
    output logic                       ack,
    output logic [bus_pkg::DATA_W-1:0] rdata,

    // Interrupts
    input  logic                       ext_int,
    input  logic                       int_ack,
    output logic                       irq,
    output logic [bus_pkg::ADDR_W-1:0] int_addr,
    output logic [bus_pkg::BE_W-1:0]   int_byteen
);

    logic tc0_irq;
    logic tc1_irq;

    dev_bus_if cpu_bus (.clk(clk));
    dev_bus_if ram_bus (.clk(clk));
    dev_bus_if tc0_bus (.clk(clk));
    dev_bus_if tc1_bus (.clk(clk));

    host_port u_host (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .addr  (addr),
        .wdata (wdata),
        .be    (be),
        .ack   (ack),
        .rdata (rdata),
        .bus   (cpu_bus)
    );

    sys_bridge u_bridge (
        .ext_int    (ext_int),
        .int_ack    (int_ack),
        .cpu        (cpu_bus),
        .ram        (ram_bus),
        .tc0        (tc0_bus),
        .tc1        (tc1_bus),
        .int_addr   (int_addr),
        .int_byteen (int_byteen)
    );

    timer_counter u_tc0 (
        .clk (clk),
        .rst (rst),
        .bus (tc0_bus),
        .irq (tc0_irq)
    );

    timer_counter u_tc1 (
        .clk (clk),
        .rst (rst),
        .bus (tc1_bus),
        .irq (tc1_irq)
    );

    data_ram u_ram (
        .clk (clk),
        .bus (ram_bus)
    );

    // Either timer raises the shared line
    assign irq = tc0_irq | tc1_irq;

endmodule

//--- logic/sys_bridge.sv
module sys_bridge (
    input  logic                       ext_int,
    input  logic                       int_ack,
    dev_bus_if.dev                     cpu,
    dev_bus_if.host                    ram,
    dev_bus_if.host                    tc0,
    dev_bus_if.host                    tc1,
    output logic [bus_pkg::ADDR_W-1:0] int_addr,
    output logic [bus_pkg::BE_W-1:0]   int_byteen
);

    logic hit_ram;
    logic hit_tc0;
    logic hit_tc1;
    logic hit_int;
    logic int_wr;

    function automatic logic in_window(
        input logic [bus_pkg::ADDR_W-1:0] a,
        input logic [bus_pkg::ADDR_W-1:0] base,
        input logic [bus_pkg::ADDR_W-1:0] last
    );
        return (a >= base) && (a <= last);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    assign hit_ram = in_window(cpu.addr, map_pkg::RAM_BASE, map_pkg::RAM_LAST);
    assign hit_tc0 = in_window(cpu.addr, map_pkg::TC0_BASE, map_pkg::TC0_LAST);
    assign hit_tc1 = in_window(cpu.addr, map_pkg::TC1_BASE, map_pkg::TC1_LAST);
    assign hit_int = in_window(cpu.addr, map_pkg::INT_BASE, map_pkg::INT_LAST);

    // Same address, data and lanes go to every device
    assign ram.addr  = cpu.addr;
    assign ram.wdata = cpu.wdata;
    assign ram.be    = cpu.be;
    assign tc0.addr  = cpu.addr;
    assign tc0.wdata = cpu.wdata;
    assign tc0.be    = cpu.be;
    assign tc1.addr  = cpu.addr;
    assign tc1.wdata = cpu.wdata;
    assign tc1.be    = cpu.be;

    // Only the device that was hit sees sel
    assign ram.sel = cpu.sel && hit_ram;
    assign tc0.sel = cpu.sel && hit_tc0;
    assign tc1.sel = cpu.sel && hit_tc1;

    // Unmapped reads come back as zero
    always_comb begin
        if (hit_ram) begin
            cpu.rdata = ram.rdata;
        end else if (hit_tc0) begin
            cpu.rdata = tc0.rdata;
        end else if (hit_tc1) begin
            cpu.rdata = tc1.rdata;
        end else begin
            cpu.rdata = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupt device response port
    //////////////////////////////////////////////////////////////////////
    assign int_wr = cpu.sel && bus_pkg::is_write(cpu.be) && hit_int;

    always_comb begin
        if (ext_int && int_ack) begin
            // Acknowledge cycle of the external interrupt
            int_addr   = map_pkg::INT_BASE;
            int_byteen = 4'b0001;
        end else if (int_wr) begin
            int_addr   = cpu.addr;
            int_byteen = 4'b0001;
        end else begin
            int_addr   = '0;
            int_byteen = '0;
        end
    end

    dev_sel_onehot: assert property (@(posedge cpu.clk)
        $onehot0({ram.sel, tc0.sel, tc1.sel}))
        else $error("more than one device selected");

endmodule

//--- logic/timer_counter.sv
module timer_counter (
    input  logic    clk,
    input  logic    rst,
    dev_bus_if.dev  bus,
    output logic    irq
);

    logic [map_pkg::CTRL_W-1:0]      ctrl;
    logic [bus_pkg::DATA_W-1:0]      preset;
    logic [bus_pkg::DATA_W-1:0]      count;
    logic [map_pkg::CTRL_MODE_W-1:0] mode;
    logic [3:0]                      reg_off;
    logic [bus_pkg::DATA_W-1:0]      ctrl_word;
    logic [bus_pkg::DATA_W-1:0]      ctrl_new;
    logic [bus_pkg::DATA_W-1:0]      preset_new;
    logic                            wr;
    logic                            wr_ctrl;
    logic                            wr_preset;
    logic                            oneshot;
    logic                            reload;
    logic                            tick;
    logic                            expire;

    //////////////////////////////////////////////////////////////////////
    // Register access
    //////////////////////////////////////////////////////////////////////
    assign reg_off   = {bus.addr[3:2], 2'b00};
    assign wr        = bus.sel && bus_pkg::is_write(bus.be);
    assign wr_ctrl   = wr && (reg_off == map_pkg::TC_CTRL);
    assign wr_preset = wr && (reg_off == map_pkg::TC_PRESET);

    assign ctrl_word  = {{(bus_pkg::DATA_W - map_pkg::CTRL_W){1'b0}}, ctrl};
    assign ctrl_new   = bus_pkg::merge_bytes(ctrl_word, bus.wdata, bus.be);
    assign preset_new = bus_pkg::merge_bytes(preset, bus.wdata, bus.be);

    // COUNT is read-only from the bus
    always_comb begin
        case (reg_off)
            map_pkg::TC_CTRL:   bus.rdata = ctrl_word;
            map_pkg::TC_PRESET: bus.rdata = preset;
            map_pkg::TC_COUNT:  bus.rdata = count;
            default:            bus.rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Countdown
    //////////////////////////////////////////////////////////////////////
    assign mode    = ctrl[map_pkg::CTRL_MODE_LO +: map_pkg::CTRL_MODE_W];
    assign oneshot = (mode == map_pkg::MODE_ONESHOT);
    assign reload  = (mode == map_pkg::MODE_RELOAD);
    assign tick    = ctrl[map_pkg::CTRL_EN] && (count != '0);

    // Last decrement this cycle, unless a PRESET write overrides it
    assign expire = tick && (count == 1) && !wr_preset;

    always_ff @(posedge clk) begin
        if (rst) begin
            preset <= '0;
            count  <= '0;
        end else if (wr_preset) begin
            preset <= preset_new;
            count  <= preset_new;
        end else if (expire && reload) begin
            count <= preset;
        end else if (tick) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (wr_ctrl) begin
            ctrl <= ctrl_new[map_pkg::CTRL_W-1:0];
        end else if (expire && oneshot) begin
            ctrl[map_pkg::CTRL_EN] <= 1'b0;
        end
    end

    // One-shot holds irq until CTRL is rewritten; other modes pulse it
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (wr_ctrl) begin
            irq <= 1'b0;
        end else if (expire && ctrl[map_pkg::CTRL_IM]) begin
            irq <= 1'b1;
        end else if (!oneshot) begin
            irq <= 1'b0;
        end
    end

    irq_masked: assert property (@(posedge clk) disable iff (rst)
        irq |-> ctrl[map_pkg::CTRL_IM])
        else $error("timer irq high with IM clear");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module mips_sys_tb -o mips_sys_sim \
    && ./obj_dir/mips_sys_sim | tee sim.log \
    || { echo "Verilator build or run error"; exit 1; }

grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log
